// File: logic/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// one data word
`define LC3B_WORD_W 16

// memory line, 8 words
`define LC3B_LINE_W 128

// line address, bits 15:4 of a byte address
`define LC3B_LADR_W 12

// one select per byte of a line
`define LC3B_SEL_W 16

`endif

// File: logic/lc3b_types.sv
`default_nettype none

`include "lc3b_consts.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

    // n, z, p
    typedef logic [2:0] lc3b_cc;

    // LC-3b encoding, unsupported codes kept so a decode can flag them
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        wb_alu = 2'b00,
        wb_mdr = 2'b01,
        wb_pcn = 2'b10
    } lc3b_wb_sel;

    typedef struct packed {
        lc3b_opcode opcode;
        logic       mem_read;
        logic       mem_write;
        logic       word_align;  // 0 = byte access
        logic       addr_sel;    // 1 = trap vector
        logic       cc_load;
        logic       br_en_load;
        logic       reg_write;
        lc3b_wb_sel wb_sel;
    } lc3b_control_word;

endpackage

`default_nettype wire

// File: logic/stage_link_if.sv
`timescale 1ns/1ns
`default_nettype none

// one instruction slot between two neighbouring stages
interface stage_link_if;
    logic                         valid;
    lc3b_types::lc3b_control_word control;
    lc3b_types::lc3b_word         alu;
    lc3b_types::lc3b_word         ir;
    lc3b_types::lc3b_word         pcn;
    lc3b_types::lc3b_word         sr2;
    lc3b_types::lc3b_word         mdr;  // only meaningful after memory

    modport src (
        output valid, control, alu, ir, pcn, sr2, mdr
    );

    modport dst (
        input valid, control, alu, ir, pcn, sr2, mdr
    );

endinterface

`default_nettype wire

// File: logic/stage_ex.sv
`timescale 1ns/1ns
`default_nettype none

module stage_ex (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  lc3b_types::lc3b_word in_ir,
    input  lc3b_types::lc3b_word in_pcn,
    input  lc3b_types::lc3b_word in_sr1,
    input  lc3b_types::lc3b_word in_sr2,
    stage_link_if.src            out
);
    lc3b_types::lc3b_opcode       opcode;
    lc3b_types::lc3b_control_word ctrl;
    lc3b_types::lc3b_word         imm5;
    lc3b_types::lc3b_word         off6;
    lc3b_types::lc3b_word         off9;
    lc3b_types::lc3b_word         opnd2;
    lc3b_types::lc3b_word         alu;
    logic                         reserved;

    assign opcode = lc3b_types::lc3b_opcode'(in_ir[15:12]);
    assign imm5   = {{11{in_ir[4]}}, in_ir[4:0]};
    assign off6   = {{10{in_ir[5]}}, in_ir[5:0]};
    assign off9   = {{7{in_ir[8]}}, in_ir[8:0]};
    assign opnd2  = in_ir[5] ? imm5 : in_sr2;  // ir[5] picks the immediate form

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = opcode;
        ctrl.wb_sel = lc3b_types::wb_alu;
        alu         = '0;
        reserved    = 1'b0;
        case (opcode)
            lc3b_types::op_add: begin
                ctrl.cc_load   = 1'b1;
                ctrl.reg_write = 1'b1;
                alu            = in_sr1 + opnd2;
            end
            lc3b_types::op_and: begin
                ctrl.cc_load   = 1'b1;
                ctrl.reg_write = 1'b1;
                alu            = in_sr1 & opnd2;
            end
            lc3b_types::op_not: begin
                ctrl.cc_load   = 1'b1;
                ctrl.reg_write = 1'b1;
                alu            = ~in_sr1;
            end
            lc3b_types::op_lea: begin
                ctrl.reg_write = 1'b1;  // LC-3b LEA leaves cc alone
                alu            = in_pcn + {off9[14:0], 1'b0};
            end
            lc3b_types::op_ldr, lc3b_types::op_ldb: begin
                ctrl.mem_read   = 1'b1;
                ctrl.word_align = (opcode == lc3b_types::op_ldr);
                ctrl.cc_load    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.wb_sel     = lc3b_types::wb_mdr;
                alu = (opcode == lc3b_types::op_ldr) ? in_sr1 + {off6[14:0], 1'b0}
                                                     : in_sr1 + off6;
            end
            lc3b_types::op_str, lc3b_types::op_stb: begin
                ctrl.mem_write  = 1'b1;
                ctrl.word_align = (opcode == lc3b_types::op_str);
                alu = (opcode == lc3b_types::op_str) ? in_sr1 + {off6[14:0], 1'b0}
                                                     : in_sr1 + off6;
            end
            lc3b_types::op_br: begin
                ctrl.br_en_load = 1'b1;
                alu             = in_pcn + {off9[14:0], 1'b0};  // branch target
            end
            lc3b_types::op_trap: begin
                ctrl.mem_read   = 1'b1;
                ctrl.word_align = 1'b1;
                ctrl.addr_sel   = 1'b1;
                ctrl.wb_sel     = lc3b_types::wb_mdr;  // vector word goes back as new PC
            end
            default: reserved = 1'b1;  // jsr, jmp, shf, rti, ldi, sti
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out.control <= ctrl;
        out.alu     <= alu;
        out.ir      <= in_ir;
        out.pcn     <= in_pcn;
        out.sr2     <= in_sr2;
    end

    assign out.mdr = '0;  // filled in by the memory stage

    // the front end must never hand over an opcode this pipe lacks
    a_no_reserved: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !reserved);

endmodule

`default_nettype wire

// File: logic/stage_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_consts.svh"

module stage_mem (
    input  logic                    clk,
    input  logic                    rst,
    stage_link_if.dst               in,
    stage_link_if.src               out,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [`LC3B_LADR_W-1:0] mem_ladr,
    output logic [`LC3B_SEL_W-1:0]  mem_sel,
    output logic [`LC3B_LINE_W-1:0] mem_wdata,
    input  logic [`LC3B_LINE_W-1:0] mem_rdata,
    output logic                    br_en_next,
    output lc3b_types::lc3b_cc      cc
);
    lc3b_types::lc3b_word trapvect;
    lc3b_types::lc3b_word addr;
    lc3b_types::lc3b_word store_lane;
    lc3b_types::lc3b_word load_data;
    lc3b_types::lc3b_word cc_src;
    lc3b_types::lc3b_cc   cc_new;
    logic [2:0]           lane;  // word within the line

    assign trapvect = {7'b0, in.ir[7:0], 1'b0};
    assign addr     = in.control.addr_sel ? trapvect : in.alu;
    assign lane     = addr[3:1];

    assign mem_ladr = addr[15:4];
    assign mem_req  = in.valid && (in.control.mem_read || in.control.mem_write);
    assign mem_we   = in.valid && in.control.mem_write;

    // byte selects and write data, placed in lane w
    always_comb begin
        mem_sel   = '0;
        mem_wdata = '0;
        if (in.control.word_align) begin
            mem_sel[{lane, 1'b0} +: 2] = 2'b11;
            store_lane                 = in.sr2;
        end else if (addr[0]) begin  // high byte
            mem_sel[{lane, 1'b0} +: 2] = 2'b10;
            store_lane                 = {in.sr2[7:0], 8'h00};
        end else begin  // low byte
            mem_sel[{lane, 1'b0} +: 2] = 2'b01;
            store_lane                 = {8'h00, in.sr2[7:0]};
        end
        mem_wdata[{lane, 4'b0} +: 16] = store_lane;
    end

    always_comb begin
        if (in.control.word_align) begin
            load_data = mem_rdata[{lane, 4'b0} +: 16];
        end else begin
            load_data = {8'h00, mem_rdata[{addr[3:0], 3'b0} +: 8]};  // zero extend
        end
    end

    // codes follow the value that will be written back
    assign cc_src = in.control.mem_read ? load_data : in.alu;
    assign cc_new = {cc_src[15], cc_src == '0, !cc_src[15] && (cc_src != '0)};

    always_ff @(posedge clk) begin
        if (rst) begin
            cc         <= 3'b010;
            br_en_next <= 1'b0;
            out.valid  <= 1'b0;
        end else begin
            out.valid <= in.valid;
            if (in.valid && in.control.cc_load) begin
                cc <= cc_new;
            end
            // old cc here, so a BR right behind a cc setter sees its codes
            br_en_next <= in.valid && in.control.br_en_load && |(cc & in.ir[11:9]);
        end
    end

    always_ff @(posedge clk) begin
        out.control <= in.control;
        out.alu     <= in.alu;
        out.ir      <= in.ir;
        out.pcn     <= in.pcn;
        out.sr2     <= in.sr2;
        out.mdr     <= load_data;
    end

    a_we_has_req: assert property (@(posedge clk) disable iff (rst)
        mem_we |-> mem_req);

    // operands come from outside, so alignment is theirs to keep
    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req && in.control.word_align |-> !addr[0]);

endmodule

`default_nettype wire

// File: logic/stage_wb.sv
`timescale 1ns/1ns
`default_nettype none

module stage_wb (
    input  logic                 clk,
    input  logic                 rst,
    stage_link_if.dst            in,
    input  logic                 br_en_next,
    output logic                 wb_valid,
    output logic                 wb_reg_write,
    output logic [2:0]           wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output logic                 br_en
);
    lc3b_types::lc3b_word wb_value;
    logic [2:0]           dest;

    always_comb begin
        case (in.control.wb_sel)
            lc3b_types::wb_mdr: wb_value = in.mdr;
            lc3b_types::wb_pcn: wb_value = in.pcn;
            default:            wb_value = in.alu;
        endcase
    end

    // trap reports its vector word against R7, front end takes it as new PC
    assign dest = (in.control.opcode == lc3b_types::op_trap) ? 3'd7 : in.ir[11:9];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            br_en        <= 1'b0;
        end else begin
            wb_valid     <= in.valid;
            wb_reg_write <= in.valid && in.control.reg_write;
            br_en        <= br_en_next;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= dest;
        wb_data <= wb_value;
    end

    a_write_is_valid: assert property (@(posedge clk) disable iff (rst)
        wb_reg_write |-> wb_valid);

endmodule

`default_nettype wire

// File: logic/lc3b_mem_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_consts.svh"

module lc3b_mem_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  lc3b_types::lc3b_word    in_ir,
    input  lc3b_types::lc3b_word    in_pcn,
    input  lc3b_types::lc3b_word    in_sr1,
    input  lc3b_types::lc3b_word    in_sr2,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [`LC3B_LADR_W-1:0] mem_ladr,
    output logic [`LC3B_SEL_W-1:0]  mem_sel,
    output logic [`LC3B_LINE_W-1:0] mem_wdata,
    input  logic [`LC3B_LINE_W-1:0] mem_rdata,
    output logic                    wb_valid,
    output logic                    wb_reg_write,
    output logic [2:0]              wb_dest,
    output lc3b_types::lc3b_word    wb_data,
    output logic                    br_en,
    output lc3b_types::lc3b_cc      cc
);
    logic br_en_next;  // registered in memory stage, one cycle ahead of br_en

    stage_link_if ex_to_mem ();
    stage_link_if mem_to_wb ();

    stage_ex u_stage_ex (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ir    (in_ir),
        .in_pcn   (in_pcn),
        .in_sr1   (in_sr1),
        .in_sr2   (in_sr2),
        .out      (ex_to_mem.src)
    );

    stage_mem u_stage_mem (
        .clk        (clk),
        .rst        (rst),
        .in         (ex_to_mem.dst),
        .out        (mem_to_wb.src),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_ladr   (mem_ladr),
        .mem_sel    (mem_sel),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .br_en_next (br_en_next),
        .cc         (cc)
    );

    stage_wb u_stage_wb (
        .clk          (clk),
        .rst          (rst),
        .in           (mem_to_wb.dst),
        .br_en_next   (br_en_next),
        .wb_valid     (wb_valid),
        .wb_reg_write (wb_reg_write),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data),
        .br_en        (br_en)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

// free running testbench clock, 100 ns period
module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end
endmodule

`default_nettype wire

// File: sim/tb_lc3b_mem_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_consts.svh"

module tb_lc3b_mem_pipe;
    logic                    clk, rst, in_valid;
    lc3b_types::lc3b_word    in_ir, in_pcn, in_sr1, in_sr2, wb_data;
    logic                    mem_req, mem_we, wb_valid, wb_reg_write, br_en;
    logic [`LC3B_LADR_W-1:0] mem_ladr;
    logic [`LC3B_SEL_W-1:0]  mem_sel;
    logic [`LC3B_LINE_W-1:0] mem_wdata, mem_rdata;
    logic [2:0]              wb_dest;
    lc3b_types::lc3b_cc      cc, ref_cc;
    logic [`LC3B_LINE_W-1:0] mem [0:4095];      // memory the DUT talks to
    logic [`LC3B_LINE_W-1:0] ref_mem [0:4095];  // expected contents
    lc3b_types::lc3b_word    q_ir[$], q_pcn[$], q_sr1[$], q_sr2[$];  // pending stream
    int                      errors, tests_passed, tests_failed;

    tb_clock u_tb_clock (.clk(clk));

    lc3b_mem_pipe u_lc3b_mem_pipe (.*);

    assign mem_rdata = mem[mem_ladr];  // combinational read

    always @(posedge clk) begin
        if (mem_req && mem_we) begin
            for (int b = 0; b < `LC3B_SEL_W; b++) begin
                if (mem_sel[b]) mem[mem_ladr][b*8 +: 8] <= mem_wdata[b*8 +: 8];
            end
        end
    end

    initial begin
        #2_000_000;
        $display("simulation hit its time limit");
        $display("TEST FAILED");
        $finish;
    end

    // word at a byte address, mixed so that every address bit counts
    function automatic lc3b_types::lc3b_word fill_word(int line, int w);
        logic [15:0] a;
        a = {line[11:0], w[2:0], 1'b0};
        return (a * 16'h9e37) ^ 16'h5a5a;
    endfunction

    function automatic lc3b_types::lc3b_cc cc_of(lc3b_types::lc3b_word v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    function automatic lc3b_types::lc3b_word enc(lc3b_types::lc3b_opcode op, logic [2:0] ra,
                                                 logic [2:0] rb, logic [5:0] low);
        return {op, ra, rb, low};
    endfunction

    task automatic check_word(string name, lc3b_types::lc3b_word got, lc3b_types::lc3b_word exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cc(lc3b_types::lc3b_cc got, lc3b_types::lc3b_cc exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: cc = %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // reference model of one instruction, in program order
    task automatic predict(input lc3b_types::lc3b_word ir, pcn, sr1, sr2,
                           output lc3b_types::lc3b_word data, output logic [2:0] dest,
                           output logic rw, br, chk);
        lc3b_types::lc3b_opcode op;
        lc3b_types::lc3b_word   opnd, off6, wa, ba, ta;
        op   = lc3b_types::lc3b_opcode'(ir[15:12]);
        opnd = ir[5] ? {{11{ir[4]}}, ir[4:0]} : sr2;
        off6 = {{10{ir[5]}}, ir[5:0]};
        wa   = sr1 + (off6 << 1);
        ba   = sr1 + off6;
        ta   = {7'b0, ir[7:0], 1'b0};  // trap table entry
        data = 16'h0000;
        dest = ir[11:9];
        br   = 1'b0;
        case (op)
            lc3b_types::op_add:  data = sr1 + opnd;
            lc3b_types::op_and:  data = sr1 & opnd;
            lc3b_types::op_not:  data = ~sr1;
            lc3b_types::op_lea:  data = pcn + ({{7{ir[8]}}, ir[8:0]} << 1);
            lc3b_types::op_ldr:  data = ref_mem[wa[15:4]][wa[3:1]*16 +: 16];
            lc3b_types::op_ldb:  data = {8'h00, ref_mem[ba[15:4]][ba[3:0]*8 +: 8]};
            lc3b_types::op_str:  ref_mem[wa[15:4]][wa[3:1]*16 +: 16] = sr2;
            lc3b_types::op_stb:  ref_mem[ba[15:4]][ba[3:0]*8 +: 8] = sr2[7:0];
            lc3b_types::op_br:   br = |(ref_cc & ir[11:9]);
            lc3b_types::op_trap: begin
                data = ref_mem[ta[15:4]][ta[3:1]*16 +: 16];
                dest = 3'd7;
            end
            default: data = 16'h0000;
        endcase
        rw  = op inside {lc3b_types::op_add, lc3b_types::op_and, lc3b_types::op_not,
                         lc3b_types::op_lea, lc3b_types::op_ldr, lc3b_types::op_ldb};
        chk = rw || (op == lc3b_types::op_trap);
        if (rw && op != lc3b_types::op_lea) ref_cc = cc_of(data);  // lea keeps cc
    endtask

    task automatic push(input lc3b_types::lc3b_word ir, pcn, sr1, sr2);
        q_ir.push_back(ir);
        q_pcn.push_back(pcn);
        q_sr1.push_back(sr1);
        q_sr2.push_back(sr2);
    endtask

    // issue the queue back to back and check each result as it leaves
    task automatic run_stream();
        lc3b_types::lc3b_word exp_data[$];
        lc3b_types::lc3b_cc   cc_after[$];
        logic [2:0]           exp_dest[$];
        logic                 exp_rw[$], exp_br[$], exp_chk[$], exp_req[$], exp_we[$];
        lc3b_types::lc3b_opcode op;
        lc3b_types::lc3b_word d;
        logic [2:0]           dst;
        logic                 rw, br, chk;
        int                   n, got, tick;
        n = q_ir.size();
        for (int i = 0; i < n; i++) begin
            predict(q_ir[i], q_pcn[i], q_sr1[i], q_sr2[i], d, dst, rw, br, chk);
            exp_data.push_back(d);
            exp_dest.push_back(dst);
            exp_rw.push_back(rw);
            exp_br.push_back(br);
            exp_chk.push_back(chk);
            cc_after.push_back(ref_cc);
            op = lc3b_types::lc3b_opcode'(q_ir[i][15:12]);
            exp_req.push_back(op inside {lc3b_types::op_ldr, lc3b_types::op_ldb,
                                         lc3b_types::op_str, lc3b_types::op_stb,
                                         lc3b_types::op_trap});
            exp_we.push_back(op inside {lc3b_types::op_str, lc3b_types::op_stb});
        end
        got  = 0;
        tick = 0;
        while (got < n && tick < n + 10) begin
            @(negedge clk);
            // the slot driven at the previous negedge sits in the memory stage now
            if (tick >= 1 && tick <= n) begin
                check_bit("mem_req", mem_req, exp_req[tick - 1]);
                check_bit("mem_we", mem_we, exp_we[tick - 1]);
            end else begin
                check_bit("mem_req", mem_req, 1'b0);
                check_bit("mem_we", mem_we, 1'b0);
            end
            if (wb_valid) begin
                if (tick != got + 3) begin  // issued one negedge before the input edge
                    $display("result %0d left the pipe at the wrong cycle", got);
                    errors++;
                end
                check_bit("wb_reg_write", wb_reg_write, exp_rw[got]);
                check_bit("br_en", br_en, exp_br[got]);
                check_cc(cc, cc_after[(got + 1 < n) ? got + 1 : got]);  // one instr further on
                if (exp_chk[got]) begin
                    check_word("wb_data", wb_data, exp_data[got]);
                    check_word("wb_dest", {13'b0, wb_dest}, {13'b0, exp_dest[got]});
                end
                got++;
            end
            in_valid = (tick < n);
            if (tick < n) begin
                in_ir  = q_ir[tick];
                in_pcn = q_pcn[tick];
                in_sr1 = q_sr1[tick];
                in_sr2 = q_sr2[tick];
            end
            tick++;
        end
        if (got < n) begin
            $display("timed out waiting for wb_valid, %0d of %0d results seen", got, n);
            errors++;
        end
        in_valid = 1'b0;
        q_ir.delete();
        q_pcn.delete();
        q_sr1.delete();
        q_sr2.delete();
    endtask

    task automatic check_memory();
        for (int l = 0; l < 4096; l++) begin
            for (int w = 0; w < 8; w++) begin
                if (mem[l][w*16 +: 16] !== ref_mem[l][w*16 +: 16]) begin
                    check_word($sformatf("mem[%0d] word %0d", l, w),
                               mem[l][w*16 +: 16], ref_mem[l][w*16 +: 16]);
                end
            end
        end
    endtask

    task automatic end_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    task automatic test_alu();
        lc3b_types::lc3b_opcode ops[3] = '{lc3b_types::op_add, lc3b_types::op_and,
                                           lc3b_types::op_not};
        int e;
        e = errors;
        push(enc(lc3b_types::op_add, 3'd1, 3'd2, 6'o03), 16'h3000, 16'd5, 16'hfffb);  // zero
        push(enc(lc3b_types::op_add, 3'd2, 3'd3, 6'h3f), 16'h3002, 16'h7fff, 16'h0);
        push(enc(lc3b_types::op_add, 3'd3, 3'd4, 6'h2f), 16'h3004, 16'h8000, 16'h0);
        push(enc(lc3b_types::op_and, 3'd4, 3'd1, 6'o02), 16'h0, 16'hf0f0, 16'h0ff0);
        push(enc(lc3b_types::op_and, 3'd5, 3'd1, 6'h30), 16'h0, 16'h8765, 16'h0);
        push(enc(lc3b_types::op_and, 3'd6, 3'd1, 6'h2a), 16'h0, 16'h0005, 16'h0);  // 5 & 10
        push(enc(lc3b_types::op_not, 3'd7, 3'd2, 6'h3f), 16'h0, 16'h00ff, 16'h0);
        push(enc(lc3b_types::op_not, 3'd0, 3'd2, 6'h3f), 16'h0, 16'hffff, 16'h0);
        for (int i = 0; i < 12; i++) begin
            push(enc(ops[$urandom_range(2)], 3'($urandom), 3'($urandom), 6'($urandom)),
                 16'($urandom), 16'($urandom), 16'($urandom));
        end
        run_stream();
        end_test("alu ops", e);
    endtask

    task automatic test_loads();
        lc3b_types::lc3b_word base;
        int e;
        e    = errors;
        base = {12'($urandom), 4'h0};
        for (int w = 0; w < 8; w++) push(enc(lc3b_types::op_ldr, 3'(w), 3'd1, 6'(w)), 0, base, 0);
        for (int b = 0; b < 16; b++) push(enc(lc3b_types::op_ldb, 3'(b), 3'd2, 6'(b)), 0, base, 0);
        push(enc(lc3b_types::op_ldr, 3'd1, 3'd1, 6'h3f), 0, base + 16, 0);  // negative offset
        run_stream();
        end_test("loads", e);
    endtask

    task automatic test_stores();
        lc3b_types::lc3b_word base;
        int e;
        e    = errors;
        base = {12'($urandom), 4'h0};
        push(enc(lc3b_types::op_str, 3'd1, 3'd2, 6'd2), 0, base, 16'($urandom));
        push(enc(lc3b_types::op_str, 3'd1, 3'd2, 6'd5), 0, base, 16'($urandom));
        push(enc(lc3b_types::op_stb, 3'd1, 3'd2, 6'd7), 0, base, 16'($urandom));  // high byte
        push(enc(lc3b_types::op_stb, 3'd1, 3'd2, 6'd8), 0, base, 16'($urandom));  // low byte
        for (int w = 2; w < 6; w++) push(enc(lc3b_types::op_ldr, 3'(w), 3'd2, 6'(w)), 0, base, 0);
        run_stream();
        check_memory();
        end_test("stores", e);
    endtask

    task automatic test_branch();
        lc3b_types::lc3b_word setter[3] = '{16'hfffd, 16'h0000, 16'h0009};  // n, z, p
        int e;
        e = errors;
        for (int m = 0; m < 8; m++) begin
            for (int c = 0; c < 3; c++) begin
                push(enc(lc3b_types::op_add, 3'd1, 3'd2, 6'h20), 0, setter[c], 0);
                push(enc(lc3b_types::op_br, 3'(m), 3'($urandom), 6'($urandom)),
                     16'($urandom), 0, 0);
            end
        end
        run_stream();
        end_test("branches", e);
    endtask

    task automatic test_trap();
        logic [7:0] vec[6] = '{8'h00, 8'h20, 8'h25, 8'h7e, 8'hff, 8'h00};
        int e;
        e      = errors;
        vec[5] = 8'($urandom);
        for (int i = 0; i < 6; i++) begin
            push(enc(lc3b_types::op_add, 3'd1, 3'd2, 6'(32 + i * 5)), 0, 16'(i - 2), 0);
            push({lc3b_types::op_trap, 4'h0, vec[i]}, 16'($urandom), 0, 0);
        end
        run_stream();
        end_test("traps", e);
    endtask

    task automatic test_random();
        lc3b_types::lc3b_opcode ops[10] = '{lc3b_types::op_add, lc3b_types::op_and,
            lc3b_types::op_not, lc3b_types::op_lea, lc3b_types::op_ldr, lc3b_types::op_ldb,
            lc3b_types::op_str, lc3b_types::op_stb, lc3b_types::op_br, lc3b_types::op_trap};
        lc3b_types::lc3b_opcode op;
        lc3b_types::lc3b_word   sr1;
        int e;
        e = errors;
        for (int i = 0; i < 200; i++) begin
            op  = ops[$urandom_range(9)];
            sr1 = 16'($urandom);
            if (op == lc3b_types::op_ldr || op == lc3b_types::op_str) sr1[0] = 1'b0;
            push({op, 12'($urandom)}, 16'($urandom), sr1, 16'($urandom));
        end
        run_stream();
        check_memory();
        end_test("random stream", e);
    endtask

    initial begin
        void'($urandom(85681));
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_ir        = '0;
        in_pcn       = '0;
        in_sr1       = '0;
        in_sr2       = '0;
        ref_cc       = 3'b010;
        for (int l = 0; l < 4096; l++) begin
            for (int w = 0; w < 8; w++) begin
                mem[l][w*16 +: 16]     = fill_word(l, w);
                ref_mem[l][w*16 +: 16] = fill_word(l, w);
            end
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        test_alu();
        test_loads();
        test_stores();
        test_branch();
        test_trap();
        test_random();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/lc3b_types.sv
logic/stage_link_if.sv
logic/stage_ex.sv
logic/stage_mem.sv
logic/stage_wb.sv
logic/lc3b_mem_pipe.sv
sim/tb_clock.sv
sim/tb_lc3b_mem_pipe.sv
